// File: sources.f
design/calc_pkg.sv
design/key_sync.sv
design/calc_ctrl.sv
design/result_split.sv
design/seg_encode.sv
design/digit_scan.sv
design/calc_top.sv
verif/tb_calc.sv

// File: Bender.yml
package:
  name: calc

sources:
  - design/calc_pkg.sv
  - design/key_sync.sv
  - design/calc_ctrl.sv
  - design/result_split.sv
  - design/seg_encode.sv
  - design/digit_scan.sv
  - design/calc_top.sv
  - target: simulation
    files:
      - verif/tb_calc.sv

// File: verif/tb_calc.sv
// calculator testbench with key presses, outside adder model, reference model and scan checks
module tb_calc import calc_pkg::*; ();

	localparam int clk_period    = 40;
	localparam int scan_div      = 2;  // clocks per scanned digit
	localparam int press_low     = 3;  // cycles a key is held down
	localparam int press_high    = 6;  // release after it
	localparam int settle_cycles = 6;  // press start to a stable display
	localparam int sum_rounds    = 6;
	localparam int sub_rounds    = 8;  // two fixed, six random
	localparam int clear_presses = 27; // prefixes 0..4 on plus, 2..4 on minus, each with clear
	localparam int total_presses = 5 + 4 * sum_rounds + 4 * sub_rounds + clear_presses;

	logic                CLK;
	logic                RST_X;
	logic [key_w-1:0]    psw;
	logic [result_w-1:0] sum_data;
	logic [result_w-1:0] sub_data;
	logic [digit_w-1:0]  a_data;
	logic [digit_w-1:0]  b_data;
	logic [seg_w-1:0]    seg_1_out;
	logic [3:0]          seg_sel_1;
	logic [seg_w-1:0]    seg_2_out;
	logic [3:0]          seg_sel_2;

	// reference model
	calc_state_t        exp_state;
	logic [digit_w-1:0] exp_a;
	logic [digit_w-1:0] exp_b;
	logic               exp_a_ena;
	logic               exp_b_ena;
	logic               exp_res_ena;
	int                 exp_result;
	logic [seg_w-1:0]   exp_seg_a;
	logic [seg_w-1:0]   exp_seg_b;
	logic [seg_w-1:0]   exp_seg_tens;
	logic [seg_w-1:0]   exp_seg_ones;
	logic [seg_w-1:0]   exp_seg_1;   // glyph scanner 1 should be showing
	logic [seg_w-1:0]   exp_seg_2;

	logic [3:0] sel_1_q;         // select that seg_out belongs to
	logic [3:0] sel_2_q;
	int         sel_1_hold = 0;  // samples the select has stayed put
	int         sel_2_hold = 0;
	int         cycle_cnt = 0;
	int         press_cycle = 0; // cycle count at the last press
	logic       checking;
	logic [7:0] lfsr;
	string      test_name;

	calc_top #(.scan_div(scan_div)) u_calc_top (
		.CLK       (CLK),
		.RST_X     (RST_X),
		.psw       (psw),
		.sum_data  (sum_data),
		.sub_data  (sub_data),
		.a_data    (a_data),
		.b_data    (b_data),
		.seg_1_out (seg_1_out),
		.seg_sel_1 (seg_sel_1),
		.seg_2_out (seg_2_out),
		.seg_sel_2 (seg_sel_2)
	);

	// outside adder, two's complement
	assign sum_data = result_w'(a_data) + result_w'(b_data);
	assign sub_data = result_w'(a_data) - result_w'(b_data);

	initial begin
		CLK = 1'b0;
		forever #(clk_period / 2) CLK = ~CLK;
	end

	function automatic logic [seg_w-1:0] glyph_of(input int d);
		return seg_digits[d];
	endfunction

	// active low select to the glyph of that digit
	function automatic logic [seg_w-1:0] pick_digit(input logic [3:0] sel,
		input logic [seg_w-1:0] d0, input logic [seg_w-1:0] d1,
		input logic [seg_w-1:0] d2, input logic [seg_w-1:0] d3);
		case (sel)
			4'b1110: return d0;
			4'b1101: return d1;
			4'b1011: return d2;
			4'b0111: return d3;
			default: return seg_blank;
		endcase
	endfunction

	function automatic logic [3:0] next_sel(input logic [3:0] sel);
		return {sel[2:0], sel[3]}; // digit 0 -> 1 -> 2 -> 3 -> 0
	endfunction

	// x^8 + x^6 + x^5 + x^4 + 1
	function automatic logic [7:0] lfsr_next(input logic [7:0] s);
		return s[0] ? ((s >> 1) ^ 8'hb8) : (s >> 1);
	endfunction

	always_comb begin
		exp_a_ena   = (exp_state != idle);
		exp_b_ena   = exp_state inside {sum_2, sub_2, sum_finish, sub_finish};
		exp_res_ena = exp_state inside {sum_finish, sub_finish};
		exp_result  = (exp_state == sub_finish) ? int'(exp_a) - int'(exp_b)
			: int'(exp_a) + int'(exp_b);
		exp_seg_a = exp_a_ena ? glyph_of(exp_a) : seg_blank;
		exp_seg_b = exp_b_ena ? glyph_of(exp_b) : seg_blank;
		if (!exp_res_ena) begin
			exp_seg_tens = seg_blank;
			exp_seg_ones = seg_blank;
		end else if (exp_result < 0) begin
			exp_seg_tens = seg_minus; // sign, then magnitude
			exp_seg_ones = glyph_of(-exp_result);
		end else begin
			exp_seg_tens = (exp_result >= 10) ? glyph_of(1) : seg_blank; // no leading zero
			exp_seg_ones = glyph_of(exp_result % 10);
		end
		exp_seg_1 = pick_digit(sel_1_q, seg_blank, seg_blank, exp_seg_a, seg_blank);
		exp_seg_2 = pick_digit(sel_2_q, exp_seg_b, seg_blank, exp_seg_tens, exp_seg_ones);
	end

	always @(posedge CLK) begin
		sel_1_q   <= seg_sel_1; // seg_out lags the select by a clock
		sel_2_q   <= seg_sel_2;
		cycle_cnt <= cycle_cnt + 1;
		if (!RST_X) begin
			sel_1_hold <= 0;
			sel_2_hold <= 0;
		end else begin
			sel_1_hold <= (seg_sel_1 == sel_1_q) ? sel_1_hold + 1 : 0;
			sel_2_hold <= (seg_sel_2 == sel_2_q) ? sel_2_hold + 1 : 0;
		end
	end

	assign checking = (cycle_cnt - press_cycle) >= settle_cycles; // display settled

	task automatic stop_fail;
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic value_fail(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("[FAIL] %s %s: expected %0h actual %0h", test_name, what, expected, actual);
		stop_fail;
	endtask

	task automatic plain_fail(input string msg);
		$display("%s: %s", test_name, msg);
		stop_fail;
	endtask

	assert property (@(posedge CLK) disable iff (!RST_X) checking |-> a_data == exp_a)
		else value_fail("a_data", $sampled(exp_a), $sampled(a_data));
	assert property (@(posedge CLK) disable iff (!RST_X) checking |-> b_data == exp_b)
		else value_fail("b_data", $sampled(exp_b), $sampled(b_data));
	assert property (@(posedge CLK) disable iff (!RST_X) checking |-> seg_1_out == exp_seg_1)
		else value_fail("scanner 1 segments", $sampled(exp_seg_1), $sampled(seg_1_out));
	assert property (@(posedge CLK) disable iff (!RST_X) checking |-> seg_2_out == exp_seg_2)
		else value_fail("scanner 2 segments", $sampled(exp_seg_2), $sampled(seg_2_out));
	assert property (@(posedge CLK) disable iff (!RST_X) $onehot(~seg_sel_1))
		else plain_fail("scanner 1 select does not have exactly one digit low");
	assert property (@(posedge CLK) disable iff (!RST_X) $onehot(~seg_sel_2))
		else plain_fail("scanner 2 select does not have exactly one digit low");
	assert property (@(posedge CLK) disable iff (!RST_X)
		seg_sel_1 != sel_1_q |-> seg_sel_1 == next_sel(sel_1_q))
		else value_fail("scanner 1 order", next_sel($sampled(sel_1_q)), $sampled(seg_sel_1));
	assert property (@(posedge CLK) disable iff (!RST_X)
		seg_sel_2 != sel_2_q |-> seg_sel_2 == next_sel(sel_2_q))
		else value_fail("scanner 2 order", next_sel($sampled(sel_2_q)), $sampled(seg_sel_2));
	assert property (@(posedge CLK) disable iff (!RST_X)
		seg_sel_1 == sel_1_q |-> sel_1_hold < scan_div)
		else plain_fail("scanner 1 select stayed on one digit too long");
	assert property (@(posedge CLK) disable iff (!RST_X)
		seg_sel_2 == sel_2_q |-> sel_2_hold < scan_div)
		else plain_fail("scanner 2 select stayed on one digit too long");

	// reference state machine, one key at a time
	task automatic apply_key(input int k);
		if (k == key_clear) begin
			exp_state = idle; // from anywhere
		end else if (k <= key_digit_top) begin
			case (exp_state)
				idle, step_1, sum_finish, sub_finish: begin
					exp_a     = digit_w'(k);
					exp_state = step_1;
				end
				sum_1: begin
					exp_b     = digit_w'(k);
					exp_state = sum_2;
				end
				sub_1: begin
					exp_b     = digit_w'(k);
					exp_state = sub_2;
				end
				default: exp_state = exp_state; // operator expected, digit dropped
			endcase
		end else if (exp_state == step_1 && k == key_add) begin
			exp_state = sum_1;
		end else if (exp_state == step_1 && k == key_sub) begin
			exp_state = sub_1;
		end else if (k == key_equal && exp_state inside {sum_2, sub_2}) begin
			exp_state = (exp_state == sum_2) ? sum_finish : sub_finish;
		end
	endtask

	// called on a falling edge, returns on one
	task automatic press_key(input int k);
		psw[k]      = 1'b0;
		press_cycle = cycle_cnt;
		apply_key(k);
		repeat (press_low) @(negedge CLK);
		psw[k] = 1'b1;
		repeat (press_high) @(negedge CLK);
	endtask

	task automatic rand_digit(output int d);
		logic [3:0] v;
		v = 4'hf;
		while (v > 4'd9) begin // reject 10..15
			for (int i = 0; i < 4; i++) begin
				v    = {v[2:0], lfsr[0]};
				lfsr = lfsr_next(lfsr); // one step per bit
			end
		end
		d = int'(v);
	endtask

	// first n keys of digit, op, digit, equal
	task automatic press_prefix(input int op, input int n);
		int d;
		for (int i = 0; i < n; i++) begin
			rand_digit(d);
			press_key((i == 1) ? op : (i == 3) ? key_equal : d);
		end
	endtask

	task automatic run_calc(input int a, input int op, input int b);
		press_key(a);
		press_key(op);
		press_key(b);
		press_key(key_equal);
	endtask

	initial begin
		int d;
		int e;
		psw       = '1; // all keys up
		RST_X     = 1'b0;
		lfsr      = 8'd78;
		exp_state = idle;
		exp_a     = '0;
		exp_b     = '0;
		test_name = "reset";
		repeat (4) @(negedge CLK);
		RST_X = 1'b1;
		repeat (12) @(negedge CLK); // blank scan after reset

		test_name = "first_digit";
		rand_digit(d);
		press_key(d);

		test_name = "ignored_keys";
		press_key(key_clear);
		press_key(key_add);
		press_key(key_sub);
		press_key(key_equal);

		test_name = "sum";
		repeat (sum_rounds) begin
			rand_digit(d);
			rand_digit(e);
			run_calc(d, key_add, e);
		end

		test_name = "sub";
		run_calc(3, key_sub, 7); // negative result
		run_calc(7, key_sub, 3);
		repeat (sub_rounds - 2) begin
			rand_digit(d);
			rand_digit(e);
			run_calc(d, key_sub, e);
		end

		test_name = "clear";
		for (int p = 0; p <= 4; p++) begin
			press_prefix(key_add, p);
			press_key(key_clear);
		end
		for (int p = 2; p <= 4; p++) begin
			press_prefix(key_sub, p);
			press_key(key_clear);
		end
		repeat (16) @(negedge CLK); // two full scans blank

		$display("Simulation finished: PASS");
		$finish;
	end

	// watchdog
	initial begin
		repeat (total_presses * (press_low + press_high) + 200) @(posedge CLK);
		$display("timeout: key sequence did not finish within %0d presses", total_presses);
		stop_fail;
	end

endmodule

// File: design/calc_top.sv
// calculator top that joins key input, controller, result path, encoders and scanners
module calc_top import calc_pkg::*; #(
	parameter int unsigned scan_div = scan_div_default
) (
	input  logic                CLK,
	input  logic                RST_X,
	input  logic [key_w-1:0]    psw,
	input  logic [result_w-1:0] sum_data,  // from the outside adder
	input  logic [result_w-1:0] sub_data,
	output logic [digit_w-1:0]  a_data,    // operands to the adder
	output logic [digit_w-1:0]  b_data,
	output logic [seg_w-1:0]    seg_1_out,
	output logic [3:0]          seg_sel_1,
	output logic [seg_w-1:0]    seg_2_out,
	output logic [3:0]          seg_sel_2
);

	logic [key_w-1:0]   key_strobe;
	logic               digit_valid;
	logic [digit_w-1:0] digit_code;
	logic               a_ena;
	logic               b_ena;
	logic               result_ena;
	logic               sub_sel;
	logic [digit_w-1:0] tens_digit;
	logic [digit_w-1:0] ones_digit;
	logic [seg_w-1:0]   seg_a;
	logic [seg_w-1:0]   seg_b;
	logic [seg_w-1:0]   seg_tens;
	logic [seg_w-1:0]   seg_ones;

	key_sync u_key_sync (
		.CLK         (CLK),
		.RST_X       (RST_X),
		.psw         (psw),
		.key_strobe  (key_strobe),
		.digit_valid (digit_valid),
		.digit_code  (digit_code)
	);

	calc_ctrl u_calc_ctrl (
		.CLK         (CLK),
		.RST_X       (RST_X),
		.key_strobe  (key_strobe),
		.digit_valid (digit_valid),
		.digit_code  (digit_code),
		.a_data      (a_data),
		.b_data      (b_data),
		.a_ena       (a_ena),
		.b_ena       (b_ena),
		.result_ena  (result_ena),
		.sub_sel     (sub_sel)
	);

	result_split u_result_split (
		.CLK        (CLK),
		.RST_X      (RST_X),
		.sum_data   (sum_data),
		.sub_data   (sub_data),
		.sub_sel    (sub_sel),
		.tens_digit (tens_digit),
		.ones_digit (ones_digit)
	);

	seg_encode u_seg_a (.digit(a_data), .ena(a_ena), .seg(seg_a));
	seg_encode u_seg_b (.digit(b_data), .ena(b_ena), .seg(seg_b));
	seg_encode #(.blank_zero(1'b1)) u_seg_tens (.digit(tens_digit), .ena(result_ena),
		.seg(seg_tens)); // no leading zero
	seg_encode u_seg_ones (.digit(ones_digit), .ena(result_ena), .seg(seg_ones));

	// scanner 1 shows A on digit 2 only
	digit_scan #(.scan_div(scan_div)) u_scan_1 (
		.CLK     (CLK),
		.RST_X   (RST_X),
		.seg_0   (seg_blank),
		.seg_1   (seg_blank),
		.seg_2   (seg_a),
		.seg_3   (seg_blank),
		.seg_out (seg_1_out),
		.seg_sel (seg_sel_1)
	);

	// scanner 2 shows B, gap, tens, ones
	digit_scan #(.scan_div(scan_div)) u_scan_2 (
		.CLK     (CLK),
		.RST_X   (RST_X),
		.seg_0   (seg_b),
		.seg_1   (seg_blank),
		.seg_2   (seg_tens),
		.seg_3   (seg_ones),
		.seg_out (seg_2_out),
		.seg_sel (seg_sel_2)
	);

endmodule

// File: design/digit_scan.sv
// four digit display scanner that rotates the digit gate and registers the segment bus
module digit_scan import calc_pkg::*; #(
	parameter int unsigned scan_div = scan_div_default // clocks per digit
) (
	input  logic             CLK,
	input  logic             RST_X,
	input  logic [seg_w-1:0] seg_0,
	input  logic [seg_w-1:0] seg_1,
	input  logic [seg_w-1:0] seg_2,
	input  logic [seg_w-1:0] seg_3,
	output logic [seg_w-1:0] seg_out,
	output logic [3:0]       seg_sel  // active low digit select
);

	localparam int cnt_w = (scan_div > 1) ? $clog2(scan_div) : 1;

	logic [cnt_w-1:0] div_cnt;
	logic             tick;    // last cycle of the current digit
	logic [3:0]       gate;    // one hot, digit 0 in bit 0

	assign tick = (div_cnt == cnt_w'(scan_div - 1));

	always_ff @(posedge CLK or negedge RST_X) begin
		if (!RST_X)
			div_cnt <= '0;
		else if (tick)
			div_cnt <= '0; // wrap
		else
			div_cnt <= div_cnt + 1'b1;
	end

	always_ff @(posedge CLK or negedge RST_X) begin
		if (!RST_X)
			gate <= 4'b0001; // start on digit 0
		else if (tick)
			gate <= {gate[2:0], gate[3]}; // 0 -> 1 -> 2 -> 3 -> 0
	end

	// segment bus lags the gate by one clock
	always_ff @(posedge CLK or negedge RST_X) begin
		if (!RST_X) begin
			seg_out <= '0;
		end else begin
			case (gate)
				4'b0001: seg_out <= seg_0;
				4'b0010: seg_out <= seg_1;
				4'b0100: seg_out <= seg_2;
				4'b1000: seg_out <= seg_3;
				default: seg_out <= seg_blank;
			endcase
		end
	end

	assign seg_sel = ~gate;

	assert property (@(posedge CLK) disable iff (!RST_X) $onehot(~seg_sel))
		else $error("digit select not one hot");

endmodule

// File: design/seg_encode.sv
// seven segment encoder for one digit code with minus, error and optional zero blanking
module seg_encode import calc_pkg::*; #(
	parameter bit blank_zero = 1'b0 // set for a leading tens digit
) (
	input  logic [digit_w-1:0] digit,
	input  logic               ena,
	output logic [seg_w-1:0]   seg
);

	always_comb begin
		if (!ena) begin
			seg = seg_blank; // digit off
		end else begin
			case (digit)
				4'd0:        seg = blank_zero ? seg_blank : seg_digits[0];
				4'd1:        seg = seg_digits[1];
				4'd2:        seg = seg_digits[2];
				4'd3:        seg = seg_digits[3];
				4'd4:        seg = seg_digits[4];
				4'd5:        seg = seg_digits[5];
				4'd6:        seg = seg_digits[6];
				4'd7:        seg = seg_digits[7];
				4'd8:        seg = seg_digits[8];
				4'd9:        seg = seg_digits[9];
				digit_minus: seg = seg_minus;
				default:     seg = seg_error; // codes 10..14
			endcase
		end
	end

endmodule

// File: design/result_split.sv
// result path that picks sum or difference and registers sign or tens plus ones
module result_split import calc_pkg::*; (
	input  logic                CLK,
	input  logic                RST_X,
	input  logic [result_w-1:0] sum_data,
	input  logic [result_w-1:0] sub_data,
	input  logic                sub_sel,
	output logic [digit_w-1:0]  tens_digit,
	output logic [digit_w-1:0]  ones_digit
);

	logic [result_w-1:0] sel_data;
	logic [result_w-1:0] mag;      // magnitude of a negative value
	logic [result_w-1:0] less_ten; // value minus ten
	logic [digit_w-1:0]  tens_nxt;
	logic [digit_w-1:0]  ones_nxt;

	always_comb begin
		sel_data = sub_sel ? sub_data : sum_data;
		mag      = -sel_data;
		less_ten = sel_data - result_w'(10);
		if (sel_data[result_w-1]) begin
			tens_nxt = digit_minus; // -9..-1
			ones_nxt = mag[digit_w-1:0];
		end else if (sel_data >= result_w'(10)) begin
			tens_nxt = 4'd1; // 10..19
			ones_nxt = less_ten[digit_w-1:0];
		end else begin
			tens_nxt = 4'd0; // blanked later by the encoder
			ones_nxt = sel_data[digit_w-1:0];
		end
	end

	always_ff @(posedge CLK or negedge RST_X) begin
		if (!RST_X) begin
			tens_digit <= '0;
			ones_digit <= '0;
		end else begin
			tens_digit <= tens_nxt;
			ones_digit <= ones_nxt;
		end
	end

endmodule

// File: design/calc_ctrl.sv
// calculator controller with the operand registers and the display enables
module calc_ctrl import calc_pkg::*; (
	input  logic               CLK,
	input  logic               RST_X,
	input  logic [key_w-1:0]   key_strobe,
	input  logic               digit_valid,
	input  logic [digit_w-1:0] digit_code,
	output logic [digit_w-1:0] a_data,
	output logic [digit_w-1:0] b_data,
	output logic               a_ena,
	output logic               b_ena,
	output logic               result_ena,
	output logic               sub_sel     // difference selected for the result
);

	calc_state_t state;
	calc_state_t state_nxt;

	logic press_add;
	logic press_sub;
	logic press_clr;
	logic press_eq;
	logic load_a;
	logic load_b;

	assign press_add = key_strobe[key_add];
	assign press_sub = key_strobe[key_sub];
	assign press_clr = key_strobe[key_clear];
	assign press_eq  = key_strobe[key_equal];

	always_comb begin
		state_nxt = state; // stay unless a used key arrives
		if (press_clr) begin
			state_nxt = idle; // clear wins in every state
		end else begin
			case (state)
				idle: begin
					if (digit_valid)
						state_nxt = step_1;
				end
				step_1: begin
					if (press_add)
						state_nxt = sum_1;
					else if (press_sub)
						state_nxt = sub_1;
				end
				sum_1: begin
					if (digit_valid)
						state_nxt = sum_2;
				end
				sub_1: begin
					if (digit_valid)
						state_nxt = sub_2;
				end
				sum_2: begin
					if (press_eq)
						state_nxt = sum_finish;
				end
				sub_2: begin
					if (press_eq)
						state_nxt = sub_finish;
				end
				sum_finish, sub_finish: begin
					if (digit_valid)
						state_nxt = step_1; // new A starts over
				end
				default: state_nxt = idle;
			endcase
		end
	end

	// enables follow the state being entered
	always_ff @(posedge CLK or negedge RST_X) begin
		if (!RST_X) begin
			state      <= idle;
			a_ena      <= 1'b0;
			b_ena      <= 1'b0;
			result_ena <= 1'b0;
			sub_sel    <= 1'b0;
		end else begin
			state      <= state_nxt;
			a_ena      <= (state_nxt != idle);
			b_ena      <= state_nxt inside {sum_2, sub_2, sum_finish, sub_finish};
			result_ena <= state_nxt inside {sum_finish, sub_finish};
			sub_sel    <= state_nxt inside {sub_1, sub_2, sub_finish};
		end
	end

	// which operand takes the digit
	assign load_a = digit_valid && !press_clr &&
		(state inside {idle, step_1, sum_finish, sub_finish});
	assign load_b = digit_valid && !press_clr && (state inside {sum_1, sub_1});

	always_ff @(posedge CLK or negedge RST_X) begin
		if (!RST_X) begin
			a_data <= '0;
			b_data <= '0;
		end else begin
			if (load_a)
				a_data <= digit_code;
			if (load_b)
				b_data <= digit_code;
		end
	end

	// result never shown without its second operand
	assert property (@(posedge CLK) disable iff (!RST_X) result_ena |-> b_ena)
		else $error("result enabled while B is blank");

endmodule

// File: design/key_sync.sv
// key input block that synchronises the buttons, makes press strobes and decodes digits
module key_sync import calc_pkg::*; (
	input  logic               CLK,
	input  logic               RST_X,
	input  logic [key_w-1:0]   psw,         // active low buttons
	output logic [key_w-1:0]   key_strobe,  // one pulse per press
	output logic               digit_valid,
	output logic [digit_w-1:0] digit_code
);

	logic [key_w-1:0] sync_0; // first stage, inverted
	logic [key_w-1:0] sync_1;
	logic [key_w-1:0] sync_2; // delayed copy for edge detect

	always_ff @(posedge CLK or negedge RST_X) begin
		if (!RST_X) begin
			sync_0 <= '0;
			sync_1 <= '0;
			sync_2 <= '0;
		end else begin
			sync_0 <= ~psw; // pressed reads as one from here on
			sync_1 <= sync_0;
			sync_2 <= sync_1;
		end
	end

	assign key_strobe = sync_1 & ~sync_2; // rising edge of the pressed level

	assign digit_valid = |key_strobe[key_digit_top:0];

	// highest digit wins when several strobe together
	always_comb begin
		digit_code = '1; // all ones when no digit
		for (int i = 0; i <= key_digit_top; i++) begin
			if (key_strobe[i])
				digit_code = digit_w'(i); // later index overrides
		end
	end

	// a held key must not strobe again
	assert property (@(posedge CLK) disable iff (!RST_X)
		(key_strobe & $past(key_strobe)) == '0)
		else $error("key strobe high for two cycles");

endmodule

// File: design/calc_pkg.sv
// calc package with key map, digit and segment widths, glyph table and controller states
package calc_pkg;

	// key bank
	localparam int key_w         = 14; // push buttons on the board
	localparam int key_digit_top = 9;  // keys 0..9 are digits 0..9
	localparam int key_equal     = 10;
	localparam int key_clear     = 11;
	localparam int key_sub       = 12;
	localparam int key_add       = 13;

	// data widths
	localparam int digit_w  = 4; // one bcd digit or a glyph code
	localparam int result_w = 6; // two's complement from the outside adder
	localparam int seg_w    = 8; // a in msb, dp in lsb

	localparam logic [digit_w-1:0] digit_minus = 4'd15; // shows as a minus sign

	// glyphs, a b c d e f g dp
	localparam logic [seg_w-1:0] seg_blank = 8'b0000_0000;
	localparam logic [seg_w-1:0] seg_minus = 8'b0000_0010; // g only
	localparam logic [seg_w-1:0] seg_error = 8'b1001_1111; // E with dp lit

	localparam logic [seg_w-1:0] seg_digits [0:9] = '{
		8'b1111_1100, // 0
		8'b0110_0000, // 1
		8'b1101_1010, // 2
		8'b1111_0010, // 3
		8'b0110_0110, // 4
		8'b1011_0110, // 5
		8'b1011_1110, // 6
		8'b1110_0000, // 7
		8'b1111_1110, // 8
		8'b1111_0110  // 9
	};

	// clocks per scanned digit on the board
	localparam int unsigned scan_div_default = 12288;

	typedef enum logic [2:0] {
		idle,
		step_1,     // A entered, waiting for an operator
		sum_1,
		sum_2,
		sub_1,
		sub_2,
		sum_finish, // result shown
		sub_finish
	} calc_state_t;

endpackage
